// ==== hdl/serial_bus_pkg.sv ====
// shared widths, access delays and counter widths for the serial slave
// received frame struct and the FSM state enums
package serial_bus_pkg;

	localparam int ADDR_W          = 12;
	localparam int DATA_W          = 8;
	localparam int MEM_DEPTH       = 1 << ADDR_W;

	localparam int FAST_DELAY      = 1; // wait cycles, bit 11 clear
	localparam int SLOW_DELAY      = 8; // wait cycles, bit 11 set
	localparam int SPLIT_THRESHOLD = 5; // delays at or above this split

	localparam int ADDR_CNT_W      = $clog2(ADDR_W);
	localparam int BIT_CNT_W       = $clog2(DATA_W);
	localparam int DLY_W           = $clog2(SLOW_DELAY + 1);

	// one complete frame as seen by the controller and memory
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic              is_write;
	} rx_frame_t;

	typedef enum logic {
		RX_IDLE,
		RX_SHIFT
	} rx_state_t;

	typedef enum logic [1:0] {
		NORMAL,
		WAIT,
		SPLIT,
		VALID
	} port_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_SHIFT
	} tx_state_t;

endpackage

// ==== hdl/slave_in_port.sv ====
// serial receiver for one bus frame
// 12 address bits, 8 data bits on writes, both LSB first
`timescale 1ns/1ps

module slave_in_port import serial_bus_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      master_valid,
	input  logic      read_en,
	input  logic      write_en,
	input  logic      rx_address,
	input  logic      rx_data,
	input  logic      slave_ready,
	output logic      rx_done,
	output rx_frame_t frame
);

	rx_state_t               state;
	logic [ADDR_CNT_W-1:0]   bit_cnt;
	logic                    is_write;
	logic [ADDR_W-1:0]       addr_sr;
	logic [DATA_W-1:0]       data_sr;
	logic                    take;
	logic                    last;

	// a new frame only starts while the slave is ready
	assign take = master_valid &&
		((state == RX_IDLE) ? (slave_ready && (read_en || write_en)) : 1'b1);
	assign last = (state == RX_SHIFT) && master_valid &&
		(bit_cnt == ADDR_CNT_W'(ADDR_W - 1));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= RX_IDLE;
			bit_cnt  <= '0;
			is_write <= 1'b0;
			rx_done  <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0; // single cycle pulse
			case (state)
				RX_IDLE:
				begin
					if (take)
					begin
						state    <= RX_SHIFT;
						bit_cnt  <= ADDR_CNT_W'(1); // bit 0 taken now
						is_write <= write_en;
					end
				end
				RX_SHIFT:
				begin
					if (!master_valid)
					begin
						state   <= RX_IDLE; // master gave up
						bit_cnt <= '0;
					end
					else if (last)
					begin
						state   <= RX_IDLE;
						bit_cnt <= '0;
						rx_done <= 1'b1;
					end
					else
						bit_cnt <= bit_cnt + ADDR_CNT_W'(1);
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// shift registers and the frame output
	always_ff @(posedge clk)
	begin
		if (take)
			addr_sr <= {rx_address, addr_sr[ADDR_W-1:1]};
		if (take && (bit_cnt < ADDR_CNT_W'(DATA_W)))
			data_sr <= {rx_data, data_sr[DATA_W-1:1]}; // first 8 bits only
		if (last)
		begin
			frame.addr     <= {rx_address, addr_sr[ADDR_W-1:1]};
			frame.data     <= data_sr;
			frame.is_write <= is_write;
		end
	end

endmodule

// ==== hdl/slave_out_port.sv ====
// serial transmitter for one read byte, LSB first
// holds the current bit while the master is not ready
`timescale 1ns/1ps

module slave_out_port import serial_bus_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              slave_valid,
	input  logic              master_ready,
	input  logic [DATA_W-1:0] rdata,
	output logic              tx_data,
	output logic              slave_tx_done
);

	tx_state_t            state;
	logic                 valid_q;
	logic                 load;
	logic [BIT_CNT_W-1:0] bit_cnt; // index of bit on tx_data
	logic [DATA_W-1:0]    shift_q;

	assign load = (state == TX_IDLE) && slave_valid && !valid_q; // rising edge

	// bit 0 is visible in the load cycle itself
	assign tx_data = (state == TX_SHIFT) ? shift_q[0] : (load & rdata[0]);

	assign slave_tx_done = (state == TX_SHIFT) && master_ready &&
		(bit_cnt == BIT_CNT_W'(DATA_W - 1));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= TX_IDLE;
			valid_q <= 1'b0;
			bit_cnt <= '0;
		end
		else
		begin
			valid_q <= slave_valid;
			if (load)
			begin
				state   <= TX_SHIFT;
				bit_cnt <= master_ready ? BIT_CNT_W'(1) : '0;
			end
			else if ((state == TX_SHIFT) && master_ready)
			begin
				if (slave_tx_done)
					state <= TX_IDLE;
				bit_cnt <= bit_cnt + BIT_CNT_W'(1); // wraps to 0 after bit 7
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shift_q <= master_ready ? {1'b0, rdata[DATA_W-1:1]} : rdata;
		else if ((state == TX_SHIFT) && master_ready)
			shift_q <= {1'b0, shift_q[DATA_W-1:1]};
	end

endmodule

// ==== hdl/slave_memory.sv ====
// 4096 x 8 storage for the slave
// write on rx_done of a write frame, registered read otherwise
`timescale 1ns/1ps

module slave_memory import serial_bus_pkg::*; (
	input  logic              clk,
	input  logic              rx_done,
	input  rx_frame_t         frame,
	output logic [DATA_W-1:0] rdata
);

	logic [DATA_W-1:0] mem [MEM_DEPTH];

	always_ff @(posedge clk)
	begin
		if (rx_done)
		begin
			if (frame.is_write)
				mem[frame.addr] <= frame.data;
			else
				rdata <= mem[frame.addr]; // held until the next read
		end
	end

endmodule

// ==== hdl/slave_port.sv ====
// slave controller FSM
// picks in-place wait or split transfer from the address region
// drives slave_valid, slave_ready and split_en from the state
`timescale 1ns/1ps

module slave_port import serial_bus_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      rx_done,
	input  rx_frame_t frame,
	input  logic      slave_tx_done,
	output logic      slave_valid,
	output logic      slave_ready,
	output logic      split_en
);

	port_state_t      state;
	logic [DLY_W-1:0] dly_cnt; // remaining wait cycles minus one
	logic [DLY_W-1:0] req_dly;
	logic             rd_start;

	// bit 11 selects the slow region
	assign req_dly = frame.addr[ADDR_W-1] ? DLY_W'(SLOW_DELAY) : DLY_W'(FAST_DELAY);

	assign rd_start = rx_done && !frame.is_write; // writes need no action

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= NORMAL;
			dly_cnt <= '0;
		end
		else
		begin
			case (state)
				NORMAL:
				begin
					if (rd_start)
					begin
						dly_cnt <= req_dly - DLY_W'(1);
						if (req_dly >= DLY_W'(SPLIT_THRESHOLD))
							state <= SPLIT; // long access, release the bus
						else
							state <= WAIT;
					end
				end
				WAIT, SPLIT:
				begin
					if (dly_cnt == '0)
						state <= VALID;
					else
						dly_cnt <= dly_cnt - DLY_W'(1);
				end
				VALID:
				begin
					if (slave_tx_done)
						state <= NORMAL; // last bit is out
				end
				default: state <= NORMAL;
			endcase
		end
	end

	assign split_en    = (state == SPLIT);
	assign slave_valid = (state == VALID);
	assign slave_ready = (state == NORMAL); // low while a read is pending

endmodule

// ==== hdl/serial_slave_top.sv ====
// top level of the serial bus slave
// in port, controller, memory and out port
`timescale 1ns/1ps

module serial_slave_top import serial_bus_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic master_valid,
	input  logic read_en,
	input  logic write_en,
	input  logic rx_address,
	input  logic rx_data,
	input  logic master_ready,
	output logic tx_data,
	output logic slave_valid,
	output logic slave_ready,
	output logic split_en
);

	logic              rx_done;
	rx_frame_t         frame;
	logic [DATA_W-1:0] rdata;
	logic              slave_tx_done;

	slave_in_port u_in_port (
		.clk          (clk),
		.arst_n       (arst_n),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.slave_ready  (slave_ready),
		.rx_done      (rx_done),
		.frame        (frame)
	);

	slave_port u_slave_port (
		.clk           (clk),
		.arst_n        (arst_n),
		.rx_done       (rx_done),
		.frame         (frame),
		.slave_tx_done (slave_tx_done),
		.slave_valid   (slave_valid),
		.slave_ready   (slave_ready),
		.split_en      (split_en)
	);

	slave_memory u_memory (
		.clk     (clk),
		.rx_done (rx_done),
		.frame   (frame),
		.rdata   (rdata)
	);

	slave_out_port u_out_port (
		.clk           (clk),
		.arst_n        (arst_n),
		.slave_valid   (slave_valid),
		.master_ready  (master_ready),
		.rdata         (rdata),
		.tx_data       (tx_data),
		.slave_tx_done (slave_tx_done)
	);

endmodule

// ==== verification/serial_slave_sva.sv ====
// bound assertions on the slave controller
// split timing, ready during reads and writes
`timescale 1ns/1ps

module serial_slave_sva import serial_bus_pkg::*; (
	input logic        clk,
	input logic        arst_n,
	input logic        rx_done,
	input rx_frame_t   frame,
	input logic        slave_valid,
	input logic        slave_ready,
	input logic        split_en
);

	// split lasts the slow delay, then data are presented with split low
	split_then_valid: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(split_en) |-> ##(SLOW_DELAY - 1) split_en ##1 (slave_valid && !split_en))
		else $error("split_en not held for the slow delay before slave_valid");

	read_drops_ready: assert property (@(posedge clk) disable iff (!arst_n)
		(rx_done && !frame.is_write) |=> !slave_ready)
		else $error("slave_ready still high after a read frame");

	write_keeps_ready: assert property (@(posedge clk) disable iff (!arst_n)
		(rx_done && frame.is_write) |-> slave_ready)
		else $error("slave_ready low at the end of a write frame");

	write_ready_after: assert property (@(posedge clk) disable iff (!arst_n)
		(rx_done && frame.is_write) |=> slave_ready)
		else $error("slave_ready dropped after a write frame");

endmodule

bind slave_port serial_slave_sva u_sva (
	.clk         (clk),
	.arst_n      (arst_n),
	.rx_done     (rx_done),
	.frame       (frame),
	.slave_valid (slave_valid),
	.slave_ready (slave_ready),
	.split_en    (split_en)
);

// ==== verification/serial_slave_tb.sv ====
// testbench for the serial bus slave
// serial master driver, reference memory model, read monitor and compare process
`timescale 1ns/1ps

module serial_slave_tb import serial_bus_pkg::*; ();

	localparam int RESET_CYCLES   = 8;
	localparam int N_FRAMES       = 20;
	localparam int TIMEOUT_CYCLES = N_FRAMES * 40;
	localparam int N_READS        = 13;

	logic clk;
	logic arst_n;
	logic master_valid;
	logic read_en;
	logic write_en;
	logic rx_address;
	logic rx_data;
	logic master_ready;
	logic tx_data;
	logic slave_valid;
	logic slave_ready;
	logic split_en;

	int                seed = 94294;
	int                cycles = 0;
	int                cmp_idx = 0; // reads compared so far
	int                bit_idx = 0;
	logic [DATA_W-1:0] rx_byte;
	logic              split_seen = 1'b0;
	logic [DATA_W-1:0] ref_mem [MEM_DEPTH]; // last byte written per address
	logic [ADDR_W-1:0] rd_addr_q [$];
	logic [DATA_W-1:0] got_q [$];
	logic              split_q [$];
	logic [ADDR_W-1:0] fast_addr [4];
	logic [ADDR_W-1:0] slow_addr [3];
	logic [31:0]       rnd;

	serial_slave_top uut (
		.clk          (clk),
		.arst_n       (arst_n),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.master_ready (master_ready),
		.tx_data      (tx_data),
		.slave_valid  (slave_valid),
		.slave_ready  (slave_ready),
		.split_en     (split_en)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
		return ref_mem[addr];
	endfunction

	// slow region splits whenever its delay reaches the threshold
	function automatic logic ref_split(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-1] && (SLOW_DELAY >= SPLIT_THRESHOLD);
	endfunction

	function automatic int ref_latency(input logic [ADDR_W-1:0] addr);
		return (addr[ADDR_W-1] ? SLOW_DELAY : FAST_DELAY) + 1;
	endfunction

	task automatic check_data(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch tx_data at address %h: got %h, expected %h", addr, got, exp);
			abort_run();
		end
	endtask

	task automatic check_split(input logic [ADDR_W-1:0] addr, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch split_en at address %h: got %h, expected %h", addr, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("Mismatch %s: got %h cycles, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// 12 address bits, data bits on the first 8 cycles, LSB first
	task automatic send_frame(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic is_wr);
		for (int i = 0; i < ADDR_W; i++)
		begin
			@(posedge clk);
			#1;
			master_valid = 1'b1;
			read_en      = !is_wr;
			write_en     = is_wr;
			rx_address   = addr[i];
			rx_data      = (i < DATA_W) ? data[i] : 1'b0;
		end
		@(posedge clk);
		#1;
		master_valid = 1'b0;
		read_en      = 1'b0;
		write_en     = 1'b0;
		rx_address   = 1'b0;
		rx_data      = 1'b0;
	endtask

	task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		ref_mem[addr] = data;
		send_frame(addr, data, 1'b1);
		repeat (2)
		begin
			@(negedge clk);
			check_flag("slave_ready after write", slave_ready, 1'b1);
		end
	endtask

	// n counts cycles from the rx_done cycle
	task automatic send_read(input logic [ADDR_W-1:0] addr, input logic bp);
		int   n;
		logic seen;
		logic done;
		rd_addr_q.push_back(addr);
		send_frame(addr, '0, 1'b0);
		n    = 0;
		seen = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			if (slave_valid && !seen)
			begin
				seen = 1'b1;
				check_count("read latency", n, ref_latency(addr));
			end
			done = seen && !slave_valid;
			check_flag("slave_ready during read", slave_ready, (n == 0) || done);
			check_split(addr, split_en, ref_split(addr) && (n > 0) && !seen); // whole wait
			@(posedge clk);
			#1 master_ready = bp ? (($random(seed) & 3) != 0) : 1'b1;
			n++;
		end
		master_ready = 1'b1;
	endtask

	// read monitor, one bit per valid and ready cycle
	always @(negedge clk)
	begin
		if (split_en)
			split_seen = 1'b1;
		if (slave_valid && master_ready)
		begin
			rx_byte[bit_idx] = tx_data;
			if (bit_idx == DATA_W - 1)
			begin
				got_q.push_back(rx_byte);
				split_q.push_back(split_seen);
				split_seen = 1'b0;
				bit_idx    = 0;
			end
			else
				bit_idx++;
		end
	end

	// compare process
	always @(posedge clk)
	begin
		if (cmp_idx < got_q.size())
		begin
			check_data(rd_addr_q[cmp_idx], got_q[cmp_idx], ref_read(rd_addr_q[cmp_idx]));
			check_split(rd_addr_q[cmp_idx], split_q[cmp_idx], ref_split(rd_addr_q[cmp_idx]));
			cmp_idx++;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the test did not finish", cycles);
			abort_run();
		end
	end

	initial
	begin
		arst_n       = 1'b0;
		master_valid = 1'b0;
		read_en      = 1'b0;
		write_en     = 1'b0;
		rx_address   = 1'b0;
		rx_data      = 1'b0;
		master_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1;
		@(negedge clk);
		check_flag("slave_valid after reset", slave_valid, 1'b0);
		check_flag("split_en after reset", split_en, 1'b0);
		check_flag("slave_ready after reset", slave_ready, 1'b1);
		check_flag("tx_data after reset", tx_data, 1'b0);

		foreach (fast_addr[i])
		begin
			rnd          = $random(seed);
			fast_addr[i] = {1'b0, rnd[ADDR_W-2:0]}; // bit 11 clear
			send_write(fast_addr[i], rnd[ADDR_W+DATA_W-1:ADDR_W]);
		end
		foreach (fast_addr[i])
			send_read(fast_addr[i], 1'b0);

		foreach (slow_addr[i])
		begin
			rnd          = $random(seed);
			slow_addr[i] = {1'b1, rnd[ADDR_W-2:0]}; // slow region
			send_write(slow_addr[i], rnd[ADDR_W+DATA_W-1:ADDR_W]);
		end
		foreach (slow_addr[i])
			send_read(slow_addr[i], 1'b0);

		// random master_ready gaps during transmission
		for (int i = 0; i < 3; i++)
		begin
			send_read(fast_addr[i], 1'b1);
			send_read(slow_addr[i], 1'b1);
		end

		repeat (2) @(posedge clk);
		if (cmp_idx == N_READS)
		begin
			$display("Test OK");
			$finish;
		end
		else
		begin
			$display("Only %0d of %0d reads returned a byte", cmp_idx, N_READS);
			abort_run();
		end
	end

endmodule

// ==== serial_bus.f ====
hdl/serial_bus_pkg.sv
hdl/slave_in_port.sv
hdl/slave_out_port.sv
hdl/slave_memory.sv
hdl/slave_port.sv
hdl/serial_slave_top.sv
verification/serial_slave_sva.sv
verification/serial_slave_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := serial_slave_tb
FILELIST  := serial_bus.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
